// ==== csi2_video_pkg.sv ====
// ------------------------------------------------
// CSI-2 video stream package
// Pixel and line count widths and types
// ------------------------------------------------

package csi2_video_pkg;

  // Width of the pixel counter, enough for any line length
  localparam int PX_CNT_W = 32;

  // Width of the line counter, enough for any frame height
  localparam int LN_CNT_W = 32;

  // Number of pixels in one line
  typedef logic [PX_CNT_W-1:0] px_cnt_t;

  // Number of lines in one frame
  typedef logic [LN_CNT_W-1:0] ln_cnt_t;

endpackage

// ==== csi2_stat_pkg.sv ====
// ------------------------------------------------
// CSI-2 link statistics package
// Counter, address and register map definitions
// ------------------------------------------------

package csi2_stat_pkg;

  localparam int STAT_CNT_W  = 32;
  localparam int STAT_WORD_W = 32;
  localparam int STAT_ADDR_W = 3;

  // Error event count
  typedef logic [STAT_CNT_W-1:0] stat_cnt_t;

  // One word returned on the read port
  typedef logic [STAT_WORD_W-1:0] stat_word_t;

  // Register address
  typedef logic [STAT_ADDR_W-1:0] stat_addr_t;

  // Register map, address 7 is unmapped and reads as zero
  localparam stat_addr_t ADDR_HDR_ERR      = stat_addr_t'(0);
  localparam stat_addr_t ADDR_CORR_HDR_ERR = stat_addr_t'(1);
  localparam stat_addr_t ADDR_CRC_ERR      = stat_addr_t'(2);
  localparam stat_addr_t ADDR_MAX_LN       = stat_addr_t'(3);
  localparam stat_addr_t ADDR_MIN_LN       = stat_addr_t'(4);
  localparam stat_addr_t ADDR_MAX_PX       = stat_addr_t'(5);
  localparam stat_addr_t ADDR_MIN_PX       = stat_addr_t'(6);

  // Frame tracking in the geometry block
  typedef enum logic {
    GEOM_IDLE,
    GEOM_IN_FRAME
  } geom_state_t;

endpackage

// ==== csi2_stat_if.sv ====
// ------------------------------------------------
// CSI-2 statistics bundle
// Carries the seven live values to the snapshot block
// ------------------------------------------------

`timescale 1ns/1ns

interface csi2_stat_if;

  import csi2_video_pkg::*;
  import csi2_stat_pkg::*;

  // Error counts
  stat_cnt_t hdr_err_cnt;
  stat_cnt_t corr_hdr_err_cnt;
  stat_cnt_t crc_err_cnt;

  // Frame and line geometry
  ln_cnt_t   max_ln;
  ln_cnt_t   min_ln;
  px_cnt_t   max_px;
  px_cnt_t   min_px;

  modport err_src  (output hdr_err_cnt, corr_hdr_err_cnt, crc_err_cnt);
  modport geom_src (output max_ln, min_ln, max_px, min_px);
  modport sink     (input  hdr_err_cnt, corr_hdr_err_cnt, crc_err_cnt,
                           max_ln, min_ln, max_px, min_px);

endinterface

// ==== csi2_err_stat.sv ====
// ------------------------------------------------
// CSI-2 error statistics
// Synchronises receiver error pulses and counts them
// ------------------------------------------------

`timescale 1ns/1ns

module csi2_err_stat
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        clear_stat_i,
  input  logic        header_err_i,
  input  logic        corr_header_err_i,
  input  logic        crc_err_i,
  csi2_stat_if.err_src stat
);

  import csi2_stat_pkg::*;

  // Bit order is header, corrected, crc
  logic [2:0] err_meta;
  logic [2:0] err_sync;

  logic       hdr_err_s;
  logic       corr_err_s;
  logic       crc_err_s;

  stat_cnt_t  hdr_cnt;
  stat_cnt_t  corr_cnt;
  stat_cnt_t  crc_cnt;

  // Two flop stages out of the receiver clock domain
  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      begin
        err_meta <= '0;
        err_sync <= '0;
      end
    else
      begin
        err_meta <= {header_err_i, corr_header_err_i, crc_err_i};
        err_sync <= err_meta;
      end

  assign hdr_err_s  = err_sync[2];
  assign corr_err_s = err_sync[1];
  assign crc_err_s  = err_sync[0];

  // Counters wrap freely, clear has priority over counting
  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      begin
        hdr_cnt  <= '0;
        corr_cnt <= '0;
        crc_cnt  <= '0;
      end
    else if (clear_stat_i)
      begin
        hdr_cnt  <= '0;
        corr_cnt <= '0;
        crc_cnt  <= '0;
      end
    else
      begin
        if (hdr_err_s)
          hdr_cnt <= hdr_cnt + 1'b1;
        // A corrected flag only counts together with a header error
        if (hdr_err_s && corr_err_s)
          corr_cnt <= corr_cnt + 1'b1;
        if (crc_err_s)
          crc_cnt <= crc_cnt + 1'b1;
      end

  assign stat.hdr_err_cnt      = hdr_cnt;
  assign stat.corr_hdr_err_cnt = corr_cnt;
  assign stat.crc_err_cnt      = crc_cnt;

endmodule

// ==== csi2_geom_stat.sv ====
// ------------------------------------------------
// CSI-2 geometry statistics
// Tracks min and max line length and frame height
// ------------------------------------------------

`timescale 1ns/1ns

module csi2_geom_stat
(
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic          clear_stat_i,
  input  logic          video_data_val_i,
  input  logic          video_proc_ready_i,
  input  logic          video_eol_i,
  input  logic          video_frame_start_i,
  csi2_stat_if.geom_src stat
);

  import csi2_video_pkg::*;
  import csi2_stat_pkg::*;

  logic        beat_acc;
  logic        eol_acc;
  logic        fs_acc;

  px_cnt_t     px_cnt;
  px_cnt_t     px_len;
  ln_cnt_t     ln_cnt;

  px_cnt_t     max_px;
  px_cnt_t     min_px;
  ln_cnt_t     max_ln;
  ln_cnt_t     min_ln;

  geom_state_t state;

  // Ready low is back-pressure, such a beat is not taken
  assign beat_acc = video_data_val_i & video_proc_ready_i;
  assign eol_acc  = beat_acc & video_eol_i;
  assign fs_acc   = beat_acc & video_frame_start_i;

  // Length of the line that ends on this beat
  assign px_len = px_cnt + 1'b1;

  // Beats in the current line
  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      px_cnt <= '0;
    else if (eol_acc)
      px_cnt <= '0;
    else if (beat_acc)
      px_cnt <= px_len;

  // Lines in the current frame, frame start wins over end of line
  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      ln_cnt <= '0;
    else if (fs_acc)
      ln_cnt <= '0;
    else if (eol_acc)
      ln_cnt <= ln_cnt + 1'b1;

  // No complete frame exists before the first frame start
  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      state <= GEOM_IDLE;
    else if (clear_stat_i)
      state <= GEOM_IDLE;
    else
      case (state)
        GEOM_IDLE:
          begin
            if (fs_acc)
              state <= GEOM_IN_FRAME;
          end
        GEOM_IN_FRAME:
          state <= GEOM_IN_FRAME;
        default:
          state <= GEOM_IDLE;
      endcase

  // Line length extremes
  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      begin
        max_px <= '0;
        min_px <= '1;
      end
    else if (clear_stat_i)
      begin
        max_px <= '0;
        min_px <= '1;
      end
    else if (eol_acc)
      begin
        if (px_len > max_px)
          max_px <= px_len;
        if (px_len < min_px)
          min_px <= px_len;
      end

  // Frame height extremes, closed frames only
  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      begin
        max_ln <= '0;
        min_ln <= '1;
      end
    else if (clear_stat_i)
      begin
        max_ln <= '0;
        min_ln <= '1;
      end
    else if (fs_acc && (state == GEOM_IN_FRAME))
      begin
        if (ln_cnt > max_ln)
          max_ln <= ln_cnt;
        if (ln_cnt < min_ln)
          min_ln <= ln_cnt;
      end

  assign stat.max_px = max_px;
  assign stat.min_px = min_px;
  assign stat.max_ln = max_ln;
  assign stat.min_ln = min_ln;

endmodule

// ==== csi2_stat_regs.sv ====
// ------------------------------------------------
// CSI-2 statistics registers
// Snapshot of all values and an addressed read port
// ------------------------------------------------

`timescale 1ns/1ns

module csi2_stat_regs
(
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     snap_i,
  input  logic                     rd_en_i,
  input  csi2_stat_pkg::stat_addr_t rd_addr_i,
  output csi2_stat_pkg::stat_word_t rd_data_o,
  output logic                     rd_val_o,
  csi2_stat_if.sink                stat
);

  import csi2_video_pkg::*;
  import csi2_stat_pkg::*;

  stat_cnt_t  snap_hdr;
  stat_cnt_t  snap_corr;
  stat_cnt_t  snap_crc;
  ln_cnt_t    snap_max_ln;
  ln_cnt_t    snap_min_ln;
  px_cnt_t    snap_max_px;
  px_cnt_t    snap_min_px;

  stat_word_t rd_word;
  stat_word_t rd_data;
  logic       rd_val;

  // Reads see a consistent set while the live values move on
  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      begin
        snap_hdr    <= '0;
        snap_corr   <= '0;
        snap_crc    <= '0;
        snap_max_ln <= '0;
        snap_min_ln <= '1;
        snap_max_px <= '0;
        snap_min_px <= '1;
      end
    else if (snap_i)
      begin
        snap_hdr    <= stat.hdr_err_cnt;
        snap_corr   <= stat.corr_hdr_err_cnt;
        snap_crc    <= stat.crc_err_cnt;
        snap_max_ln <= stat.max_ln;
        snap_min_ln <= stat.min_ln;
        snap_max_px <= stat.max_px;
        snap_min_px <= stat.min_px;
      end

  // Address decode
  always_comb
    case (rd_addr_i)
      ADDR_HDR_ERR:      rd_word = stat_word_t'(snap_hdr);
      ADDR_CORR_HDR_ERR: rd_word = stat_word_t'(snap_corr);
      ADDR_CRC_ERR:      rd_word = stat_word_t'(snap_crc);
      ADDR_MAX_LN:       rd_word = stat_word_t'(snap_max_ln);
      ADDR_MIN_LN:       rd_word = stat_word_t'(snap_min_ln);
      ADDR_MAX_PX:       rd_word = stat_word_t'(snap_max_px);
      ADDR_MIN_PX:       rd_word = stat_word_t'(snap_min_px);
      default:           rd_word = '0;
    endcase

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      rd_val <= 1'b0;
    else
      rd_val <= rd_en_i;

  always_ff @(posedge clk_i)
    if (rd_en_i)
      rd_data <= rd_word;

  assign rd_val_o  = rd_val;
  assign rd_data_o = rd_data;

endmodule

// ==== csi2_stat_top.sv ====
// ------------------------------------------------
// CSI-2 link statistics top level
// Error and geometry blocks with snapshot read port
// ------------------------------------------------

`timescale 1ns/1ns

module csi2_stat_top
(
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      clear_stat_i,

  // Error pulses from the receiver clock domain
  input  logic                      header_err_i,
  input  logic                      corr_header_err_i,
  input  logic                      crc_err_i,

  // Video beats in the pixel clock domain
  input  logic                      video_data_val_i,
  input  logic                      video_proc_ready_i,
  input  logic                      video_eol_i,
  input  logic                      video_frame_start_i,

  // Snapshot and read port
  input  logic                      snap_i,
  input  logic                      rd_en_i,
  input  csi2_stat_pkg::stat_addr_t rd_addr_i,
  output csi2_stat_pkg::stat_word_t rd_data_o,
  output logic                      rd_val_o
);

  csi2_stat_if stat_bus ();

  csi2_err_stat u_err_stat
  (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .clear_stat_i      (clear_stat_i),
    .header_err_i      (header_err_i),
    .corr_header_err_i (corr_header_err_i),
    .crc_err_i         (crc_err_i),
    .stat              (stat_bus.err_src)
  );

  csi2_geom_stat u_geom_stat
  (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .clear_stat_i        (clear_stat_i),
    .video_data_val_i    (video_data_val_i),
    .video_proc_ready_i  (video_proc_ready_i),
    .video_eol_i         (video_eol_i),
    .video_frame_start_i (video_frame_start_i),
    .stat                (stat_bus.geom_src)
  );

  csi2_stat_regs u_stat_regs
  (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .snap_i    (snap_i),
    .rd_en_i   (rd_en_i),
    .rd_addr_i (rd_addr_i),
    .rd_data_o (rd_data_o),
    .rd_val_o  (rd_val_o),
    .stat      (stat_bus.sink)
  );

endmodule

// ==== tb_csi2_stat.sv ====
// ------------------------------------------------
// Testbench for the CSI-2 link statistics block
// ------------------------------------------------

`timescale 1ns/1ns

module tb_csi2_stat;

  import csi2_video_pkg::*;
  import csi2_stat_pkg::*;

  // About twice the length of all tests together
  localparam int CYCLE_LIMIT = 20000;

  logic clk_i, rst_i, clear_stat_i, snap_i, rd_en_i, rd_val_o;
  logic header_err_i, corr_header_err_i, crc_err_i;
  logic video_data_val_i, video_proc_ready_i, video_eol_i, video_frame_start_i;
  stat_addr_t rd_addr_i;
  stat_word_t rd_data_o;

  // Live model values, then the snapshot copy
  stat_cnt_t m_hdr, m_corr, m_crc, s_hdr, s_corr, s_crc;
  px_cnt_t   m_max_px, m_min_px, m_px, s_max_px, s_min_px;
  ln_cnt_t   m_max_ln, m_min_ln, m_ln, s_max_ln, s_min_ln;
  bit        m_in_frame;

  stat_addr_t addr_q[$];
  stat_word_t exp_q[$];
  int         issue_q[$];
  stat_addr_t cmp_addr;
  stat_word_t cmp_word;
  int         issued;
  int         checks, errors, cycles, mark;

  csi2_stat_top uut (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Expected read word for an address from the snapshot model
  function automatic stat_word_t expected_word(input stat_addr_t addr);
    case (addr)
      ADDR_HDR_ERR:      return stat_word_t'(s_hdr);
      ADDR_CORR_HDR_ERR: return stat_word_t'(s_corr);
      ADDR_CRC_ERR:      return stat_word_t'(s_crc);
      ADDR_MAX_LN:       return stat_word_t'(s_max_ln);
      ADDR_MIN_LN:       return stat_word_t'(s_min_ln);
      ADDR_MAX_PX:       return stat_word_t'(s_max_px);
      ADDR_MIN_PX:       return stat_word_t'(s_min_px);
      default:           return '0;
    endcase
  endfunction

  task automatic check_cnt(input stat_addr_t addr, input stat_cnt_t got, input stat_cnt_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR %0t: count at address %0d is %0h, expected %0h", $time, addr, got, exp);
    end
  endtask

  task automatic check_px(input stat_addr_t addr, input px_cnt_t got, input px_cnt_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR %0t: pixels at address %0d is %0h, expected %0h", $time, addr, got, exp);
    end
  endtask

  task automatic check_ln(input stat_addr_t addr, input ln_cnt_t got, input ln_cnt_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR %0t: lines at address %0d is %0h, expected %0h", $time, addr, got, exp);
    end
  endtask

  // Each returned word belongs to the oldest outstanding read
  always @(negedge clk_i)
    if (rd_val_o === 1'b1)
    begin
      if (addr_q.size() == 0)
      begin
        errors++;
        $display("Read data came back at %0t with no read outstanding", $time);
      end
      else
      begin
        cmp_addr = addr_q.pop_front();
        cmp_word = exp_q.pop_front();
        issued = issue_q.pop_front();
        if (cycles != issued + 1)
        begin
          errors++;
          $display("Read data at %0t came %0d cycles after its request instead of one",
                   $time, cycles - issued);
        end
        case (cmp_addr)
          ADDR_MAX_LN, ADDR_MIN_LN: check_ln(cmp_addr, ln_cnt_t'(rd_data_o), ln_cnt_t'(cmp_word));
          ADDR_MAX_PX, ADDR_MIN_PX: check_px(cmp_addr, px_cnt_t'(rd_data_o), px_cnt_t'(cmp_word));
          default: check_cnt(cmp_addr, stat_cnt_t'(rd_data_o), stat_cnt_t'(cmp_word));
        endcase
      end
    end

  task automatic clear_model();
    m_hdr = '0;
    m_corr = '0;
    m_crc = '0;
    m_max_px = '0;
    m_min_px = '1;
    m_max_ln = '0;
    m_min_ln = '1;
    m_in_frame = 1'b0;
  endtask

  task automatic take_snapshot();
    @(negedge clk_i);
    snap_i = 1'b1;
    s_hdr = m_hdr;
    s_corr = m_corr;
    s_crc = m_crc;
    s_max_px = m_max_px;
    s_min_px = m_min_px;
    s_max_ln = m_max_ln;
    s_min_ln = m_min_ln;
    @(negedge clk_i);
    snap_i = 1'b0;
  endtask

  // Back-to-back reads of all eight addresses, then wait for the data
  task automatic read_all();
    for (int a = 0; a < 8; a++)
    begin
      @(negedge clk_i);
      rd_en_i = 1'b1;
      rd_addr_i = stat_addr_t'(a);
      addr_q.push_back(rd_addr_i);
      exp_q.push_back(expected_word(rd_addr_i));
      issue_q.push_back(cycles);
    end
    @(negedge clk_i);
    rd_en_i = 1'b0;
    while (addr_q.size() != 0)
      @(negedge clk_i);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  // The counter moves two edges after the pulse, so callers leave a gap
  task automatic pulse_errors(input logic hdr, input logic corr, input logic crc);
    @(negedge clk_i);
    header_err_i = hdr;
    corr_header_err_i = corr;
    crc_err_i = crc;
    @(negedge clk_i);
    header_err_i = 1'b0;
    corr_header_err_i = 1'b0;
    crc_err_i = 1'b0;
    if (hdr)
      m_hdr = m_hdr + 1;
    if (hdr && corr)
      m_corr = m_corr + 1;
    if (crc)
      m_crc = m_crc + 1;
  endtask

  task automatic model_beat(input logic eol, input logic fs);
    px_cnt_t len;
    if (fs)
    begin
      // The first frame start closes no frame
      if (m_in_frame && m_ln > m_max_ln)
        m_max_ln = m_ln;
      if (m_in_frame && m_ln < m_min_ln)
        m_min_ln = m_ln;
      m_in_frame = 1'b1;
      m_ln = '0;
    end
    else if (eol)
      m_ln = m_ln + 1;
    len = m_px + 1;
    if (eol)
    begin
      if (len > m_max_px)
        m_max_px = len;
      if (len < m_min_px)
        m_min_px = len;
      m_px = '0;
    end
    else
      m_px = len;
  endtask

  // Random stalls with flags that must be ignored, then one accepted beat
  task automatic send_beat(input logic eol, input logic fs);
    int stalls;
    stalls = $urandom_range(0, 3);
    repeat (stalls)
    begin
      @(negedge clk_i);
      video_data_val_i = 1'($urandom_range(0, 1));
      video_proc_ready_i = video_data_val_i ? 1'b0 : 1'($urandom_range(0, 1));
      video_eol_i = 1'($urandom_range(0, 1));
      video_frame_start_i = 1'($urandom_range(0, 1));
    end
    @(negedge clk_i);
    video_data_val_i = 1'b1;
    video_proc_ready_i = 1'b1;
    video_eol_i = eol;
    video_frame_start_i = fs;
    model_beat(eol, fs);
  endtask

  task automatic send_frame(input int lines);
    int len;
    for (int l = 0; l < lines; l++)
    begin
      len = $urandom_range(1, 40);
      for (int b = 0; b < len; b++)
        send_beat(b == len - 1, l == 0 && b == 0);
    end
  endtask

  task automatic video_idle();
    @(negedge clk_i);
    video_data_val_i = 1'b0;
    video_proc_ready_i = 1'b0;
    video_eol_i = 1'b0;
    video_frame_start_i = 1'b0;
  endtask

  task automatic report_test(input string name);
    if (errors == mark)
      $display("%s: ok", name);
    else
      $display("%s: %0d errors", name, errors - mark);
    mark = errors;
  endtask

  initial
  begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT)
    begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("TEST FAIL");
    $finish;
  end

  initial
  begin
    void'($urandom(59558));
    {rst_i, clear_stat_i, snap_i, rd_en_i} = 4'b1000;
    {header_err_i, corr_header_err_i, crc_err_i} = 3'b000;
    {video_data_val_i, video_proc_ready_i, video_eol_i, video_frame_start_i} = 4'b0000;
    rd_addr_i = '0;
    checks = 0;
    errors = 0;
    mark = 0;
    m_px = '0;
    m_ln = '0;
    clear_model();
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    if (rd_val_o !== 1'b0)
    begin
      errors++;
      $display("Read valid is not low after reset");
    end

    take_snapshot();
    read_all();
    report_test("reset values");

    // A corrected flag on its own first
    pulse_errors(1'b0, 1'b1, 1'b0);
    idle_cycles(3);
    for (int i = 0; i < 200; i++)
    begin
      pulse_errors(1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)),
                   1'($urandom_range(0, 1)));
      idle_cycles($urandom_range(2, 4));
    end
    idle_cycles(3);
    take_snapshot();
    read_all();
    report_test("error counting");

    for (int f = 0; f < 10; f++)
      send_frame($urandom_range(2, 8));
    video_idle();
    take_snapshot();
    read_all();
    report_test("line geometry");

    for (int f = 0; f < 12; f++)
      send_frame($urandom_range(1, 16));
    send_beat(1'b0, 1'b1);
    video_idle();
    take_snapshot();
    read_all();
    report_test("frame geometry");

    @(negedge clk_i);
    clear_stat_i = 1'b1;
    clear_model();
    @(negedge clk_i);
    clear_stat_i = 1'b0;
    take_snapshot();
    read_all();
    for (int i = 0; i < 5; i++)
    begin
      pulse_errors(1'b1, 1'($urandom_range(0, 1)), 1'b1);
      idle_cycles(2);
    end
    send_frame(3);
    send_beat(1'b0, 1'b1);
    video_idle();
    idle_cycles(3);
    // Snapshot still holds the cleared values
    read_all();
    take_snapshot();
    read_all();
    report_test("clear and snapshot");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== list.f ====
csi2_video_pkg.sv
csi2_stat_pkg.sv
csi2_stat_if.sv
csi2_err_stat.sv
csi2_geom_stat.sv
csi2_stat_regs.sv
csi2_stat_top.sv
tb_csi2_stat.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the CSI-2 statistics testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_csi2_stat -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit 1
fi

if echo "$output" | grep -q "^TEST PASS$"; then
  exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
